/* bench/mem_unit_checker.sv */
`timescale 1ns/1ps

module mem_unit_checker (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_req,
    input  logic                     i_ack,
    input  lsu_types_pkg::xdata_t    i_rdata,
    input  logic                     i_fault
);

    // ack is cleared by every reset edge.
    ack_low_in_reset: assert property (@(posedge i_clk) i_rst |=> !i_ack)
        else $error("o_ack high during reset");

    ack_rise_needs_req: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_ack) |-> i_req)
        else $error("o_ack rose while i_req was low");

    ack_held_while_req: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_ack && i_req) |=> i_ack)
        else $error("o_ack dropped while i_req was still high");

    // one cycle in the response FSM after req falls.
    ack_falls_after_req: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(i_req) |=> !i_ack)
        else $error("o_ack did not fall after i_req fell");

    result_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_ack && $past(i_ack)) |-> ($stable(i_rdata) && $stable(i_fault)))
        else $error("o_rdata or o_fault changed while o_ack was high");

endmodule

bind mem_unit_top mem_unit_checker u_checker (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (i_req),
    .i_ack   (o_ack),
    .i_rdata (o_rdata),
    .i_fault (o_fault)
);

/* bench/mem_unit_tb.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module mem_unit_tb;

    import lsu_types_pkg::*;
    import mem_op_pkg::*;

    localparam int RAM_WORDS = `LSU_RAM_DEPTH;
    localparam int MEM_BYTES = RAM_WORDS * `LSU_DATA_WIDTH / `LSU_BYTE_WIDTH;
    localparam int TIMEOUT   = 50; // cycles per wait.

    typedef logic [$clog2(MEM_BYTES) - 1 : 0] bidx_t;

    logic      clk;
    logic      rst;
    logic      req;
    logic      ack;
    logic      store;
    mem_size_e size;
    logic      uns;
    addr_t     base;
    offs_t     offset;
    xdata_t    wdata;
    xdata_t    rdata;
    logic      fault;

    logic [`LSU_BYTE_WIDTH - 1 : 0] shadow [MEM_BYTES]; // byte image of the RAM.
    logic [31:0] lcg_state;

    mem_unit_top dut (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_req      (req),
        .o_ack      (ack),
        .i_store    (store),
        .i_size     (size),
        .i_unsigned (uns),
        .i_base     (base),
        .i_offset   (offset),
        .i_wdata    (wdata),
        .o_rdata    (rdata),
        .o_fault    (fault)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic is_misaligned(input addr_t a, input mem_size_e sz);
        return (a & addr_t'((1 << sz) - 1)) != '0;
    endfunction

    // little endian, extended from the top byte read.
    function automatic xdata_t model_load(input addr_t a, input mem_size_e sz, input logic u);
        xdata_t v;
        int     n;
        int     i;
        v = '0;
        n = 1 << sz;
        for (i = 0; i < n; i++) v[8 * i +: 8] = shadow[bidx_t'(a + addr_t'(i))];
        if (!u && sz != SZ_D && v[8 * n - 1]) v = v | (~xdata_t'(0) << (8 * n));
        return v;
    endfunction

    function automatic void model_store(input addr_t a, input mem_size_e sz, input xdata_t wd);
        int i;
        for (i = 0; i < (1 << sz); i++) shadow[bidx_t'(a + addr_t'(i))] = wd[8 * i +: 8];
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_response(input xdata_t exp_rdata, input logic exp_fault);
        assert (rdata === exp_rdata) else begin
            $display("FAILED at %0t: o_rdata = %h, expected %h", $time, rdata, exp_rdata);
            $display("Verification failed");
            $fatal(1);
        end
        assert (fault === exp_fault) else begin
            $display("FAILED at %0t: o_fault = %b, expected %b", $time, fault, exp_fault);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic run_access(input logic st, input mem_size_e sz, input logic u,
                              input addr_t b, input offs_t o, input xdata_t wd);
        addr_t  a;
        xdata_t exp_rdata;
        logic   exp_fault;
        int     n;
        a         = b + addr_t'(o); // offset is sign extended.
        exp_fault = is_misaligned(a, sz);
        exp_rdata = '0;
        if (!exp_fault && !st) exp_rdata = model_load(a, sz, u);
        if (!exp_fault && st) model_store(a, sz, wd);
        @(posedge clk);
        #2;
        req    = 1'b1;
        store  = st;
        size   = sz;
        uns    = u;
        base   = b;
        offset = o;
        wdata  = wd;
        n = 0;
        while (!ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) stop_on_timeout("o_ack to rise");
        check_response(exp_rdata, exp_fault);
        @(posedge clk);
        #2;
        req = 1'b0;
        n = 0;
        while (ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack) stop_on_timeout("o_ack to fall");
    endtask

    initial begin
        int          w;
        int          s;
        int          u;
        int          lane;
        int          k;
        logic [31:0] r;
        addr_t       target;
        offs_t       o;
        lcg_state = 32'h36f0d5c8;
        rst    = 1'b1;
        req    = 1'b0;
        store  = 1'b0;
        size   = SZ_B;
        uns    = 1'b0;
        base   = '0;
        offset = '0;
        wdata  = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // fill every word before the first load.
        for (w = 0; w < RAM_WORDS; w++) begin
            run_access(1'b1, SZ_D, 1'b0, addr_t'(w * 8), '0, {next_random(), next_random()});
        end

        for (s = 0; s < 4; s++) begin
            for (u = 0; u < 2; u++) begin
                for (lane = 0; lane < 8; lane += (1 << s)) begin
                    run_access(1'b0, mem_size_e'(s[1:0]), u[0], addr_t'(40 + lane), '0, '0);
                end
            end
        end

        // partial stores, then the whole word.
        for (s = 0; s < 3; s++) begin
            run_access(1'b1, mem_size_e'(s[1:0]), 1'b0, addr_t'(80 + 8 * s + (1 << s)), '0,
                       {next_random(), next_random()});
            run_access(1'b0, SZ_D, 1'b0, addr_t'(80 + 8 * s), '0, '0);
        end

        run_access(1'b1, SZ_D, 1'b0, 32'h100, offs_t'(-8), {next_random(), next_random()});
        run_access(1'b0, SZ_D, 1'b0, 32'h0f0, offs_t'(8), '0);
        run_access(1'b1, SZ_W, 1'b0, 32'h840, offs_t'(4), {next_random(), next_random()});
        run_access(1'b0, SZ_W, 1'b0, 32'h048, offs_t'(-4), '0);
        run_access(1'b1, SZ_H, 1'b0, 32'h000, offs_t'(-6), {next_random(), next_random()});
        run_access(1'b0, SZ_H, 1'b1, 32'h7f0, offs_t'(10), '0);

        run_access(1'b0, SZ_H, 1'b0, 32'h31, '0, '0);
        run_access(1'b0, SZ_W, 1'b1, 32'h32, '0, '0);
        run_access(1'b0, SZ_D, 1'b0, 32'h34, '0, '0);
        run_access(1'b1, SZ_W, 1'b0, 32'h3a, '0, {next_random(), next_random()});
        run_access(1'b0, SZ_D, 1'b0, 32'h38, '0, '0);

        for (k = 0; k < 200; k++) begin
            r    = next_random();
            lane = (int'(r[4:2]) >> r[1:0]) << r[1:0];
            if (r[7:5] == 3'd0 && r[1:0] != 2'd0) lane = lane + 1; // odd lane, misaligned.
            target = addr_t'(int'(r[15:8]) * 8 + lane);
            o      = offs_t'(r[27:16]);
            run_access(r[29], mem_size_e'(r[1:0]), r[30],
                       target - addr_t'(o) + (addr_t'(r[28]) << 11), o,
                       {next_random(), next_random()});
        end

        $display("Verification passed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
hw/lsu_types_pkg.sv
hw/mem_op_pkg.sv
hw/mem_stage_if.sv
hw/mem_req_stage.sv
hw/lsu.sv
hw/data_ram.sv
hw/mem_resp_stage.sv
hw/mem_unit_top.sv
bench/mem_unit_checker.sv
bench/mem_unit_tb.sv

/* hw/data_ram.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_ram (
    input  logic                      i_clk,

    input  logic                      i_rd_en,
    input  lsu_types_pkg::ram_idx_t   i_rd_idx,
    output lsu_types_pkg::xdata_t     o_rd_data,

    input  logic                      i_wr_en,
    input  lsu_types_pkg::ram_idx_t   i_wr_idx,
    input  lsu_types_pkg::xdata_t     i_wr_data,
    input  lsu_types_pkg::wmask_t     i_wr_mask
);

    import lsu_types_pkg::*;

    localparam int unsigned BW = `LSU_BYTE_WIDTH;
    localparam int unsigned NB = $bits(wmask_t);

    xdata_t mem [`LSU_RAM_DEPTH];

    // byte-masked write.
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            for (int b = 0; b < NB; b++) begin
                if (i_wr_mask[b]) mem[i_wr_idx][b * BW +: BW] <= i_wr_data[b * BW +: BW];
            end
        end
    end

    // one-cycle read.
    always_ff @(posedge i_clk) begin
        if (i_rd_en) o_rd_data <= mem[i_rd_idx];
    end

endmodule

/* hw/lsu.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu (
    input  logic                      i_clk,
    input  logic                      i_rst,

    mem_stage_if.dst                  i_acc,
    mem_stage_if.src                  o_res,

    output logic                      o_ram_rd_en,
    output lsu_types_pkg::ram_idx_t   o_ram_rd_idx,
    input  lsu_types_pkg::xdata_t     i_ram_rd_data,

    output logic                      o_ram_wr_en,
    output lsu_types_pkg::ram_idx_t   o_ram_wr_idx,
    output lsu_types_pkg::xdata_t     o_ram_wr_data,
    output lsu_types_pkg::wmask_t     o_ram_wr_mask
);

    import lsu_types_pkg::*;
    import mem_op_pkg::*;

    localparam int unsigned DW      = `LSU_DATA_WIDTH;
    localparam int unsigned BW      = `LSU_BYTE_WIDTH;
    localparam int unsigned LANE_W  = $bits(lane_t);
    localparam int unsigned IDX_W   = $bits(ram_idx_t);
    localparam int unsigned BYTE_SH = $clog2(BW);

    lane_t     w_lane;
    wmask_t    w_size_mask;
    logic      r_valid;
    logic      r_load;
    logic      r_fault;
    lane_t     r_lane;
    mem_size_e r_size;
    logic      r_unsigned;
    xdata_t    w_word;
    xdata_t    w_ld_data;

    assign w_lane = i_acc.addr[LANE_W - 1 : 0];

    always_comb begin
        case (i_acc.size)
            SZ_B:    w_size_mask = wmask_t'(1'b1);
            SZ_H:    w_size_mask = wmask_t'(2'b11);
            SZ_W:    w_size_mask = wmask_t'(4'hf);
            default: w_size_mask = '1;
        endcase
    end

    // RAM is driven in the cycle the access arrives.
    assign o_ram_rd_en   = i_acc.valid && !i_acc.store && !i_acc.misaligned;
    assign o_ram_rd_idx  = i_acc.addr[LANE_W +: IDX_W];
    assign o_ram_wr_en   = i_acc.valid && i_acc.store && !i_acc.misaligned;
    assign o_ram_wr_idx  = i_acc.addr[LANE_W +: IDX_W];
    assign o_ram_wr_mask = w_size_mask << w_lane;
    assign o_ram_wr_data = i_acc.wdata << {w_lane, {BYTE_SH{1'b0}}};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_valid <= 1'b0;
            r_load  <= 1'b0;
            r_fault <= 1'b0;
        end
        else begin
            r_valid <= i_acc.valid;
            r_load  <= o_ram_rd_en;
            r_fault <= i_acc.valid && i_acc.misaligned;
        end
    end

    always_ff @(posedge i_clk) begin
        r_lane     <= w_lane; // follows the read by one cycle.
        r_size     <= i_acc.size;
        r_unsigned <= i_acc.unsigned_ld;
    end

    assign w_word = i_ram_rd_data >> {r_lane, {BYTE_SH{1'b0}}};

    always_comb begin
        case (r_size)
            SZ_B:    w_ld_data = {{(DW - BW){!r_unsigned && w_word[BW - 1]}},
                                  w_word[BW - 1 : 0]};
            SZ_H:    w_ld_data = {{(DW - 2 * BW){!r_unsigned && w_word[2 * BW - 1]}},
                                  w_word[2 * BW - 1 : 0]};
            SZ_W:    w_ld_data = {{(DW - 4 * BW){!r_unsigned && w_word[4 * BW - 1]}},
                                  w_word[4 * BW - 1 : 0]};
            default: w_ld_data = w_word;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_res.valid <= 1'b0;
            o_res.fault <= 1'b0;
            o_res.rdata <= '0;
        end
        else begin
            o_res.valid <= r_valid;
            o_res.fault <= r_fault;
            o_res.rdata <= r_load ? w_ld_data : '0; // stores and faults return zero.
        end
    end

    assign o_res.store       = 1'b0;
    assign o_res.size        = SZ_B;
    assign o_res.unsigned_ld = 1'b0;
    assign o_res.addr        = '0;
    assign o_res.wdata       = '0;
    assign o_res.misaligned  = 1'b0;

endmodule

/* hw/lsu_types_pkg.sv */
`include "lsu_cfg.svh"

package lsu_types_pkg;

    localparam int unsigned BYTES_PER_WORD = `LSU_DATA_WIDTH / `LSU_BYTE_WIDTH;

    typedef logic [`LSU_DATA_WIDTH - 1 : 0] xdata_t;
    typedef logic [`LSU_ADDR_WIDTH - 1 : 0] addr_t;

    typedef logic signed [`LSU_OFFS_WIDTH - 1 : 0] offs_t; // immediate offset.

    // one enable bit per byte.
    typedef logic [BYTES_PER_WORD - 1 : 0] wmask_t;

    typedef logic [$clog2(BYTES_PER_WORD) - 1 : 0] lane_t; // byte within word.

    typedef logic [$clog2(`LSU_RAM_DEPTH) - 1 : 0] ram_idx_t;

endpackage

/* hw/mem_op_pkg.sv */
package mem_op_pkg;

    // access size, log2 of the byte count.
    typedef enum logic [1 : 0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } mem_size_e;

    // response stage.
    typedef enum logic [1 : 0] {
        RS_IDLE = 2'd0, // waiting for a result.
        RS_ACK  = 2'd1, // ack held until req falls.
        RS_DONE = 2'd2  // release the request stage.
    } resp_state_e;

endpackage

/* hw/mem_req_stage.sv */
`timescale 1ns/1ps

module mem_req_stage (
    input  logic                     i_clk,
    input  logic                     i_rst,

    input  logic                     i_req,
    input  logic                     i_store,
    input  mem_op_pkg::mem_size_e    i_size,
    input  logic                     i_unsigned,
    input  lsu_types_pkg::addr_t     i_base,
    input  lsu_types_pkg::offs_t     i_offset,
    input  lsu_types_pkg::xdata_t    i_wdata,

    input  logic                     i_done,

    mem_stage_if.src                 o_acc
);

    import lsu_types_pkg::*;
    import mem_op_pkg::*;

    localparam int unsigned EXT_W = $bits(addr_t) - $bits(offs_t);

    addr_t w_addr;
    logic  w_misaligned;
    logic  w_accept;
    logic  r_busy;
    logic  r_served;

    assign w_addr = i_base + {{EXT_W{i_offset[$bits(offs_t) - 1]}}, i_offset};

    // any address bit below the access size.
    always_comb begin
        case (i_size)
            SZ_B:    w_misaligned = 1'b0;
            SZ_H:    w_misaligned = w_addr[0];
            SZ_W:    w_misaligned = |w_addr[1 : 0];
            default: w_misaligned = |w_addr[2 : 0];
        endcase
    end

    // served blocks a request that is still held high.
    assign w_accept = i_req && !r_busy && !r_served;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_busy      <= 1'b0;
            r_served    <= 1'b0;
            o_acc.valid <= 1'b0;
        end
        else begin
            o_acc.valid <= w_accept;
            if (w_accept)    r_busy <= 1'b1;
            else if (i_done) r_busy <= 1'b0;
            if (w_accept)    r_served <= 1'b1;
            else if (!i_req) r_served <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            o_acc.addr        <= w_addr;
            o_acc.store       <= i_store;
            o_acc.size        <= i_size;
            o_acc.unsigned_ld <= i_unsigned;
            o_acc.wdata       <= i_wdata;
            o_acc.misaligned  <= w_misaligned;
        end
    end

    assign o_acc.rdata = '0; // result fields unused on this hop.
    assign o_acc.fault = 1'b0;

endmodule

/* hw/mem_resp_stage.sv */
`timescale 1ns/1ps

module mem_resp_stage (
    input  logic                     i_clk,
    input  logic                     i_rst,

    mem_stage_if.dst                 i_res,

    input  logic                     i_req,
    output logic                     o_ack,
    output lsu_types_pkg::xdata_t    o_rdata,
    output logic                     o_fault,

    output logic                     o_done
);

    import mem_op_pkg::*;

    resp_state_e r_state;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state <= RS_IDLE;
            o_rdata <= '0;
            o_fault <= 1'b0;
        end
        else begin
            case (r_state)
                RS_IDLE: begin
                    if (i_res.valid) begin
                        r_state <= RS_ACK;
                        o_rdata <= i_res.rdata; // held for the whole ack.
                        o_fault <= i_res.fault;
                    end
                end
                RS_ACK: begin
                    if (!i_req) r_state <= RS_DONE;
                end
                RS_DONE: begin
                    r_state <= RS_IDLE;
                end
                default: begin
                    r_state <= RS_IDLE;
                end
            endcase
        end
    end

    assign o_ack  = (r_state == RS_ACK);

    // frees the request stage for the next access.
    assign o_done = (r_state == RS_DONE);

endmodule

/* hw/mem_stage_if.sv */
`timescale 1ns/1ps

interface mem_stage_if;

    import lsu_types_pkg::*;
    import mem_op_pkg::*;

    logic      valid;       // one-cycle pulse per access.
    logic      store;
    mem_size_e size;
    logic      unsigned_ld;
    addr_t     addr;
    xdata_t    wdata;
    logic      misaligned;
    xdata_t    rdata;
    logic      fault;

    modport src (
        output valid,
        output store,
        output size,
        output unsigned_ld,
        output addr,
        output wdata,
        output misaligned,
        output rdata,
        output fault
    );

    modport dst (
        input valid,
        input store,
        input size,
        input unsigned_ld,
        input addr,
        input wdata,
        input misaligned,
        input rdata,
        input fault
    );

endinterface

/* hw/mem_unit_top.sv */
`timescale 1ns/1ps

module mem_unit_top (
    input  logic                     i_clk,
    input  logic                     i_rst,

    input  logic                     i_req,
    output logic                     o_ack,
    input  logic                     i_store,
    input  mem_op_pkg::mem_size_e    i_size,
    input  logic                     i_unsigned,
    input  lsu_types_pkg::addr_t     i_base,
    input  lsu_types_pkg::offs_t     i_offset,
    input  lsu_types_pkg::xdata_t    i_wdata,
    output lsu_types_pkg::xdata_t    o_rdata,
    output logic                     o_fault
);

    import lsu_types_pkg::*;

    logic     done;
    logic     ram_rd_en;
    ram_idx_t ram_rd_idx;
    xdata_t   ram_rd_data;
    logic     ram_wr_en;
    ram_idx_t ram_wr_idx;
    xdata_t   ram_wr_data;
    wmask_t   ram_wr_mask;

    mem_stage_if acc_if ();
    mem_stage_if res_if ();

    mem_req_stage u_req (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_req      (i_req),
        .i_store    (i_store),
        .i_size     (i_size),
        .i_unsigned (i_unsigned),
        .i_base     (i_base),
        .i_offset   (i_offset),
        .i_wdata    (i_wdata),
        .i_done     (done),
        .o_acc      (acc_if.src)
    );

    lsu u_lsu (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_acc         (acc_if.dst),
        .o_res         (res_if.src),
        .o_ram_rd_en   (ram_rd_en),
        .o_ram_rd_idx  (ram_rd_idx),
        .i_ram_rd_data (ram_rd_data),
        .o_ram_wr_en   (ram_wr_en),
        .o_ram_wr_idx  (ram_wr_idx),
        .o_ram_wr_data (ram_wr_data),
        .o_ram_wr_mask (ram_wr_mask)
    );

    data_ram u_ram (
        .i_clk     (i_clk),
        .i_rd_en   (ram_rd_en),
        .i_rd_idx  (ram_rd_idx),
        .o_rd_data (ram_rd_data),
        .i_wr_en   (ram_wr_en),
        .i_wr_idx  (ram_wr_idx),
        .i_wr_data (ram_wr_data),
        .i_wr_mask (ram_wr_mask)
    );

    mem_resp_stage u_resp (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_res   (res_if.dst),
        .i_req   (i_req),
        .o_ack   (o_ack),
        .o_rdata (o_rdata),
        .o_fault (o_fault),
        .o_done  (done)
    );

endmodule

/* include/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// register and RAM word width.
`define LSU_DATA_WIDTH 64

// byte address width.
`define LSU_ADDR_WIDTH 32

// signed immediate offset.
`define LSU_OFFS_WIDTH 12

`define LSU_BYTE_WIDTH 8

// data RAM depth in words.
`define LSU_RAM_DEPTH 256

`endif

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module mem_unit_tb -o sim_mem_unit &&
./obj_dir/sim_mem_unit || exit 1
